// ==== Bender.yml ====
package:
  name: camera_capture

sources:
  # Packages ahead of the modules that use them
  - files:
      - design/cam_ctrl_pkg.sv
      - design/video_fmt_pkg.sv
      - design/reset_sync.sv
      - design/key_debounce.sv
      - design/zoom_step_ctrl.sv
      - design/capture_ctrl.sv
      - design/pixel_pipe.sv
      - design/camera_capture_top.sv
  - target: test
    files:
      - testbench/tb_camera_capture.sv

// ==== design/cam_ctrl_pkg.sv ====
package cam_ctrl_pkg;

    // --------------------------------------------------
    // Reset conditioning
    // --------------------------------------------------
    localparam int unsigned reset_stretch_bits = 4;   // 15 cycle stretch

    // --------------------------------------------------
    // Key debounce
    // --------------------------------------------------
    localparam int unsigned debounce_default = 540000;  // 20 ms at 27 MHz
    localparam int unsigned debounce_cnt_w   = 20;      // Covers the default hold

    typedef logic [debounce_cnt_w-1:0] debounce_cnt_t;

    // --------------------------------------------------
    // Zoom stepping
    // --------------------------------------------------
    localparam int unsigned zoom_w = 10;

    localparam logic [zoom_w-1:0] zoom_step     = zoom_w'(255);
    localparam logic [zoom_w-1:0] zoom_wrap_min = zoom_w'(768);  // Zoom-in wraps from here

    typedef enum logic [1:0] {
        ZOOM_NONE,
        ZOOM_IN,      // 00 -> 10
        ZOOM_OUT      // 11 -> 00
    } zoom_cmd_e;

    // Single-shot capture
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_RUN,
        CAP_DONE
    } capture_state_e;

endpackage

// ==== design/camera_capture_top.sv ====
`timescale 1ns/100ps

module camera_capture_top #(
    parameter int unsigned debounce_cycles = cam_ctrl_pkg::debounce_default
) (
    input  logic                            I_clk,
    input  logic                            sys_resetn,
    input  logic                            key,         // Active low
    input  logic [1:0]                      zoom,
    input  logic                            vsync,
    input  logic                            href,
    input  logic [video_fmt_pkg::raw_w-1:0] pixdata,
    output logic [1:0]                      led,
    output logic [cam_ctrl_pkg::zoom_w-1:0] zoom_level,  // To sensor config
    output logic                            resend,
    output logic                            rgb_vs,
    output logic                            rgb_hs,
    output logic                            rgb_de,
    output logic [video_fmt_pkg::rgb_w-1:0] rgb_data
);

    logic core_resetn;   // Stretched reset for all blocks
    logic key_press;
    logic capturing;

    // --------------------------------------------------
    // Reset and controls
    // --------------------------------------------------
    reset_sync reset_sync_i (
        .I_clk       (I_clk),
        .sys_resetn  (sys_resetn),
        .core_resetn (core_resetn)
    );

    key_debounce #(
        .debounce_cycles (debounce_cycles)
    ) key_debounce_i (
        .I_clk       (I_clk),
        .core_resetn (core_resetn),
        .key         (key),
        .key_press   (key_press)
    );

    zoom_step_ctrl zoom_step_ctrl_i (
        .I_clk       (I_clk),
        .core_resetn (core_resetn),
        .zoom        (zoom),
        .zoom_level  (zoom_level),
        .resend      (resend)
    );

    capture_ctrl capture_ctrl_i (
        .I_clk       (I_clk),
        .core_resetn (core_resetn),
        .key_press   (key_press),
        .vsync       (vsync),
        .capturing   (capturing),
        .led         (led)
    );

    // --------------------------------------------------
    // Live pixel path
    // --------------------------------------------------
    pixel_pipe pixel_pipe_i (
        .I_clk       (I_clk),
        .core_resetn (core_resetn),
        .vsync       (vsync),      // Camera sync reused as output sync
        .href        (href),
        .pixdata     (pixdata),
        .capturing   (capturing),
        .rgb_vs      (rgb_vs),
        .rgb_hs      (rgb_hs),
        .rgb_de      (rgb_de),
        .rgb_data    (rgb_data)
    );

endmodule

// ==== design/capture_ctrl.sv ====
`timescale 1ns/100ps

module capture_ctrl (
    input  logic       I_clk,
    input  logic       core_resetn,
    input  logic       key_press,
    input  logic       vsync,
    output logic       capturing,
    output logic [1:0] led
);

    cam_ctrl_pkg::capture_state_e state;

    // --------------------------------------------------
    // Single-shot FSM
    // --------------------------------------------------
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            state <= cam_ctrl_pkg::CAP_IDLE;
        end else begin
            case (state)
                cam_ctrl_pkg::CAP_IDLE: begin
                    if (key_press) state <= cam_ctrl_pkg::CAP_RUN;   // Arm
                end
                cam_ctrl_pkg::CAP_RUN: begin
                    if (vsync) state <= cam_ctrl_pkg::CAP_DONE;      // Frame sync ends it
                end
                cam_ctrl_pkg::CAP_DONE: begin
                    state <= cam_ctrl_pkg::CAP_DONE;                 // Held until reset
                end
                default: state <= cam_ctrl_pkg::CAP_IDLE;
            endcase
        end
    end

    // Status decode
    assign capturing = (state == cam_ctrl_pkg::CAP_RUN);
    assign led[0]    = (state == cam_ctrl_pkg::CAP_RUN);    // Capturing
    assign led[1]    = (state == cam_ctrl_pkg::CAP_DONE);   // Finished

endmodule

// ==== design/key_debounce.sv ====
`timescale 1ns/100ps

module key_debounce #(
    parameter int unsigned debounce_cycles = cam_ctrl_pkg::debounce_default
) (
    input  logic I_clk,
    input  logic core_resetn,
    input  logic key,          // Active low
    output logic key_press
);

    logic                        key_held;     // Registered, inverted key
    cam_ctrl_pkg::debounce_cnt_t hold_cnt;     // Cycles held so far
    cam_ctrl_pkg::debounce_cnt_t hold_target;

    assign hold_target = cam_ctrl_pkg::debounce_cnt_t'(debounce_cycles);

    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            key_held <= 1'b0;
        end else begin
            key_held <= ~key;
        end
    end

    // --------------------------------------------------
    // Hold counter and release detect
    // --------------------------------------------------
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            hold_cnt  <= '0;
            key_press <= 1'b0;
        end else begin
            key_press <= 1'b0;                          // One-cycle event
            if (key_held) begin
                if (hold_cnt != hold_target) begin
                    hold_cnt <= hold_cnt + 1'b1;        // Saturate at target
                end
            end else begin
                // Released. Short holds just clear
                if (hold_cnt == hold_target) key_press <= 1'b1;
                hold_cnt <= '0;
            end
        end
    end

endmodule

// ==== design/pixel_pipe.sv ====
`timescale 1ns/100ps

module pixel_pipe (
    input  logic                              I_clk,
    input  logic                              core_resetn,
    input  logic                              vsync,
    input  logic                              href,
    input  logic [video_fmt_pkg::raw_w-1:0]   pixdata,
    input  logic                              capturing,
    output logic                              rgb_vs,
    output logic                              rgb_hs,
    output logic                              rgb_de,
    output logic [video_fmt_pkg::rgb_w-1:0]   rgb_data
);

    logic [video_fmt_pkg::rgb565_w-1:0]   pix565;   // Stage one pixel
    logic [video_fmt_pkg::pipe_depth-1:0] vs_dly;   // Sync delay lines
    logic [video_fmt_pkg::pipe_depth-1:0] hs_dly;
    logic [video_fmt_pkg::pipe_depth-1:0] de_dly;   // Gated enable

    // --------------------------------------------------
    // Stage one RAW10 to RGB565 pack
    // --------------------------------------------------
    always_ff @(posedge I_clk) begin
        // Same MSBs feed all three fields for grey
        pix565 <= {pixdata[9:5], pixdata[9:4], pixdata[9:5]};
    end

    // Sync and enable travel alongside the pixel
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            vs_dly <= {video_fmt_pkg::pipe_depth{video_fmt_pkg::sync_idle}};
            hs_dly <= {video_fmt_pkg::pipe_depth{video_fmt_pkg::sync_idle}};
            de_dly <= '0;
        end else begin
            vs_dly <= {vs_dly[video_fmt_pkg::pipe_depth-2:0], vsync};
            hs_dly <= {hs_dly[video_fmt_pkg::pipe_depth-2:0], href};
            de_dly <= {de_dly[video_fmt_pkg::pipe_depth-2:0], href & capturing};
        end
    end

    // --------------------------------------------------
    // Stage two expansion to RGB888 or fill
    // --------------------------------------------------
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            rgb_data <= video_fmt_pkg::fill_color;
        end else if (de_dly[0]) begin
            rgb_data <= {pix565[15:11], 3'd0,     // r
                         pix565[10:5],  2'd0,     // g
                         pix565[4:0],   3'd0};    // b
        end else begin
            rgb_data <= video_fmt_pkg::fill_color;   // Blue outside active data
        end
    end

    assign rgb_vs = vs_dly[video_fmt_pkg::pipe_depth-1];
    assign rgb_hs = hs_dly[video_fmt_pkg::pipe_depth-1];
    assign rgb_de = de_dly[video_fmt_pkg::pipe_depth-1];

endmodule

// ==== design/reset_sync.sv ====
`timescale 1ns/100ps

module reset_sync (
    input  logic I_clk,
    input  logic sys_resetn,
    output logic core_resetn
);

    // Stretch counter saturating at all ones
    logic [cam_ctrl_pkg::reset_stretch_bits-1:0] stretch_cnt;

    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            stretch_cnt <= '0;
        end else if (!core_resetn) begin
            stretch_cnt <= stretch_cnt + 1'b1;   // Stops once released
        end
    end

    // Release when counter full
    assign core_resetn = &stretch_cnt;

endmodule

// ==== design/video_fmt_pkg.sv ====
package video_fmt_pkg;

    // --------------------------------------------------
    // Pixel widths
    // --------------------------------------------------
    localparam int unsigned raw_w    = 10;   // Camera RAW10
    localparam int unsigned rgb565_w = 16;   // Packed 5-6-5
    localparam int unsigned rgb_w    = 24;   // {r,g,b} 8 bits each

    // --------------------------------------------------
    // Output format
    // --------------------------------------------------
    // Blue outside active data
    localparam logic [rgb_w-1:0] fill_color = 24'h0000FF;

    localparam logic sync_idle = 1'b1;      // vs/hs level in reset

    // Input to output latency of the pixel path
    localparam int unsigned pipe_depth = 2;

endpackage

// ==== design/zoom_step_ctrl.sv ====
`timescale 1ns/100ps

module zoom_step_ctrl (
    input  logic                            I_clk,
    input  logic                            core_resetn,
    input  logic [1:0]                      zoom,
    output logic [cam_ctrl_pkg::zoom_w-1:0] zoom_level,
    output logic                            resend
);

    logic [1:0]              zoom_prev;   // Last sample of zoom
    cam_ctrl_pkg::zoom_cmd_e zoom_cmd;    // Stage one opcode

    // --------------------------------------------------
    // Stage one transition decode
    // --------------------------------------------------
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            zoom_prev <= 2'b00;
            zoom_cmd  <= cam_ctrl_pkg::ZOOM_NONE;
        end else begin
            zoom_prev <= zoom;
            if (zoom_prev == 2'b00 && zoom == 2'b10) begin
                zoom_cmd <= cam_ctrl_pkg::ZOOM_IN;
            end else if (zoom_prev == 2'b11 && zoom == 2'b00) begin
                zoom_cmd <= cam_ctrl_pkg::ZOOM_OUT;
            end else begin
                zoom_cmd <= cam_ctrl_pkg::ZOOM_NONE;   // Other changes ignored
            end
        end
    end

    // --------------------------------------------------
    // Stage two level update and resend
    // --------------------------------------------------
    always_ff @(posedge I_clk or negedge core_resetn) begin
        if (!core_resetn) begin
            zoom_level <= '0;
            resend     <= 1'b1;         // Initial sensor config after release
        end else begin
            resend <= (zoom_cmd != cam_ctrl_pkg::ZOOM_NONE);
            case (zoom_cmd)
                cam_ctrl_pkg::ZOOM_IN: begin
                    // Wrap to widest view near the top
                    if (zoom_level >= cam_ctrl_pkg::zoom_wrap_min) zoom_level <= '0;
                    else zoom_level <= zoom_level + cam_ctrl_pkg::zoom_step;
                end
                cam_ctrl_pkg::ZOOM_OUT: begin
                    // Floor at zero
                    if (zoom_level <= cam_ctrl_pkg::zoom_step) zoom_level <= '0;
                    else zoom_level <= zoom_level - cam_ctrl_pkg::zoom_step;
                end
                default: ;                            // Hold level
            endcase
        end
    end

endmodule

// ==== list.f ====
design/cam_ctrl_pkg.sv
design/video_fmt_pkg.sv
design/reset_sync.sv
design/key_debounce.sv
design/zoom_step_ctrl.sv
design/capture_ctrl.sv
design/pixel_pipe.sv
design/camera_capture_top.sv
testbench/tb_camera_capture.sv

// ==== testbench/tb_camera_capture.sv ====
`timescale 1ns/100ps

module tb_camera_capture;

    logic                            I_clk = 1'b0;
    logic                            sys_resetn;
    logic                            key;
    logic [1:0]                      zoom;
    logic                            vsync;
    logic                            href;
    logic [video_fmt_pkg::raw_w-1:0] pixdata;
    logic [1:0]                      led;
    logic [cam_ctrl_pkg::zoom_w-1:0] zoom_level;
    logic                            resend;
    logic                            rgb_vs;
    logic                            rgb_hs;
    logic                            rgb_de;
    logic [video_fmt_pkg::rgb_w-1:0] rgb_data;

    // Stimulus table with one entry per row in each queue
    logic       row_key[$];
    logic [1:0] row_zoom[$];
    logic       row_vsync[$];
    logic       row_href[$];
    int         row_hold[$];
    logic [1:0] row_led[$];
    int         row_zoom_level[$];
    int         row_resend_total[$];

    logic [26:0] pix_exp_q[$];       // {vs, hs, de, data} in drive order
    logic [15:0] lfsr_state = 16'd15514;
    logic        resend_count_en = 1'b0;
    int          resend_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    camera_capture_top #(.debounce_cycles(20)) dut_i (
        .I_clk(I_clk), .sys_resetn(sys_resetn), .key(key), .zoom(zoom),
        .vsync(vsync), .href(href), .pixdata(pixdata), .led(led),
        .zoom_level(zoom_level), .resend(resend), .rgb_vs(rgb_vs),
        .rgb_hs(rgb_hs), .rgb_de(rgb_de), .rgb_data(rgb_data)
    );

    always #2 I_clk = ~I_clk;   // 4 ns period

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // RGB565 pack then zero-fill expansion
    function automatic logic [23:0] rgb888_from_raw(input logic [9:0] p);
        return {p[9:5], 3'b000, p[9:4], 2'b00, p[9:5], 3'b000};
    endfunction

    task automatic draw_pixel(output logic [video_fmt_pkg::raw_w-1:0] p);
        p = '0;
        for (int i = 0; i < video_fmt_pkg::raw_w; i++) begin
            lfsr_state = lfsr_next(lfsr_state);            // One step per bit
            p = {p[video_fmt_pkg::raw_w-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s exp %0h got %0h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic add_row(input logic k, input logic [1:0] z, input logic v,
                           input logic h, input int hold, input logic [1:0] exp_led,
                           input int exp_zoom, input int exp_resend);
        row_key.push_back(k);
        row_zoom.push_back(z);
        row_vsync.push_back(v);
        row_href.push_back(h);
        row_hold.push_back(hold);
        row_led.push_back(exp_led);
        row_zoom_level.push_back(exp_zoom);
        row_resend_total.push_back(exp_resend);
    endtask

    // One cycle of stimulus
    // cap marks the expected capture state
    task automatic drive_cycle(input logic k, input logic [1:0] z, input logic v,
                               input logic h, input logic cap);
        logic [video_fmt_pkg::raw_w-1:0] p;
        logic                            de;
        logic [23:0]                     data;
        @(posedge I_clk);
        #0.5;
        draw_pixel(p);
        key     = k;
        zoom    = z;
        vsync   = v;
        href    = h;
        pixdata = p;
        de      = h & cap;
        data    = de ? rgb888_from_raw(p) : 24'h0000FF;    // Blue fill when idle
        pix_exp_q.push_back({v, h, de, data});
    endtask

    task automatic build_table();
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 4, 2'b00, 0, 1);     // Start-up resend only
        add_row(1'b1, 2'b00, 1'b0, 1'b1, 6, 2'b00, 0, 1);     // href gated before press
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 255, 2);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 255, 2);   // 10 -> 00 ignored
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 510, 3);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 510, 3);
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 765, 4);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 765, 4);
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 1020, 5);  // 765 still below wrap
        add_row(1'b1, 2'b11, 1'b0, 1'b0, 3, 2'b00, 1020, 5);  // 10 -> 11 ignored
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 765, 6);   // Zoom out
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 1020, 7);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 1020, 7);
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 0, 8);     // Wraps from 1020
        add_row(1'b1, 2'b11, 1'b0, 1'b0, 3, 2'b00, 0, 8);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 0, 9);     // Floor at zero still resends
        add_row(1'b1, 2'b10, 1'b0, 1'b0, 3, 2'b00, 255, 10);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 255, 10);
        add_row(1'b1, 2'b11, 1'b0, 1'b0, 3, 2'b00, 255, 10);  // 00 -> 11 ignored
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 3, 2'b00, 0, 11);    // Level equal to step
        add_row(1'b0, 2'b00, 1'b0, 1'b0, 15, 2'b00, 0, 11);   // Short hold
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 6, 2'b00, 0, 11);
        add_row(1'b0, 2'b00, 1'b0, 1'b0, 20, 2'b00, 0, 11);   // Exactly the hold length
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 4, 2'b01, 0, 11);    // Armed after release
        add_row(1'b1, 2'b00, 1'b0, 1'b1, 12, 2'b01, 0, 11);
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 2, 2'b01, 0, 11);
        add_row(1'b1, 2'b00, 1'b0, 1'b1, 8, 2'b01, 0, 11);
        add_row(1'b1, 2'b00, 1'b1, 1'b0, 3, 2'b10, 0, 11);    // Frame start ends capture
        add_row(1'b1, 2'b00, 1'b0, 1'b1, 8, 2'b10, 0, 11);
        add_row(1'b0, 2'b00, 1'b0, 1'b0, 25, 2'b10, 0, 11);   // Press ignored when done
        add_row(1'b1, 2'b00, 1'b0, 1'b0, 6, 2'b10, 0, 11);
        add_row(1'b1, 2'b00, 1'b1, 1'b1, 4, 2'b10, 0, 11);
    endtask

    // --------------------------------------------------
    // Monitors
    // --------------------------------------------------
    always @(negedge I_clk) begin
        logic [26:0] pix_exp;
        if (resend_count_en && resend) resend_cnt++;
        if (pix_exp_q.size() == 3) begin         // Oldest entry is two cycles old
            pix_exp = pix_exp_q.pop_front();
            check_value("rgb_vs", pix_exp[26], rgb_vs);
            check_value("rgb_hs", pix_exp[25], rgb_hs);
            check_value("rgb_de", pix_exp[24], rgb_de);
            check_value("rgb_data", pix_exp[23:0], rgb_data);
        end
    end

    always @(posedge I_clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int hold_sum;
        sys_resetn = 1'b0;
        key        = 1'b1;
        zoom       = 2'b00;
        vsync      = 1'b0;
        href       = 1'b0;
        pixdata    = '0;
        build_table();
        hold_sum = 0;
        foreach (row_hold[i]) hold_sum += row_hold[i];
        cycle_limit = 2 * hold_sum + 100;

        repeat (4) @(posedge I_clk);
        @(negedge I_clk);
        check_value("led", 2'b00, led);          // Values held in reset
        check_value("rgb_de", 1'b0, rgb_de);
        check_value("rgb_data", 24'h0000FF, rgb_data);
        check_value("rgb_vs", 1'b1, rgb_vs);
        check_value("rgb_hs", 1'b1, rgb_hs);
        @(posedge I_clk);
        #0.5 sys_resetn = 1'b1;
        repeat (15) @(posedge I_clk);            // Core reset stretch
        resend_count_en = 1'b1;
        #1;
        check_value("led", 2'b00, led);
        check_value("rgb_de", 1'b0, rgb_de);
        check_value("rgb_data", 24'h0000FF, rgb_data);

        foreach (row_hold[r]) begin
            for (int c = 0; c < row_hold[r]; c++) begin
                drive_cycle(row_key[r], row_zoom[r], row_vsync[r], row_href[r],
                            row_led[r] == 2'b01);
            end
            @(negedge I_clk);
            #0.5;                                // After the resend monitor
            check_value("led", row_led[r], led);
            check_value("zoom_level", row_zoom_level[r], zoom_level);
            check_value("resend_count", row_resend_total[r], resend_cnt);
        end

        $display("Checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
